/* rtl/oric_av_out.sv */
`timescale 1ns/100ps
`default_nettype none

module oric_av_out
	import oric_av_pkg::*;
(
	input logic clk_sys,
	input logic rst_n,
	input logic r,
	input logic g,
	input logic b,
	input logic hs,
	input logic vs,
	input logic ce_pix,
	input status_t status,
	input logic scandoubler_d,
	input logic [sample_w-1:0] audio,
	output logic [color_w-1:0] vga_r,
	output logic [color_w-1:0] vga_g,
	output logic [color_w-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic audio_out
);

	pixel_t pix; // stage 1 to stage 2.

	pixel_capture pixel_capture_i (
		.clk_sys (clk_sys),
		.rst_n (rst_n),
		.r (r),
		.g (g),
		.b (b),
		.hs (hs),
		.vs (vs),
		.ce_pix (ce_pix),
		.pix (pix)
	);

	scanline_shader scanline_shader_i (
		.clk_sys (clk_sys),
		.rst_n (rst_n),
		.pix (pix),
		.status (status),
		.scandoubler_d (scandoubler_d),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

	// same stream feeds both speakers on the board.
	sigma_delta_dac sigma_delta_dac_i (
		.clk_sys (clk_sys),
		.rst_n (rst_n),
		.audio (audio),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

/* rtl/oric_av_pkg.sv */
`default_nettype none

package oric_av_pkg;

	localparam int color_w = 6; // one vga channel.
	localparam int sample_w = 16; // psg sample width.

	// channel level for a lit colour bit.
	localparam logic [color_w-1:0] level_full = 6'd63;

	// lit level on a darkened line, by scanline mode.
	localparam logic [color_w-1:0] level_dim [0:3] = '{
		6'd63, // mode 0, no darkening.
		6'd47,
		6'd31,
		6'd15
	};

	// status word from the board controller.
	typedef struct packed {
		logic [21:0] spare_hi;
		logic reset_menu; // reset entry in the osd.
		logic [4:0] spare_mid;
		logic [1:0] scanlines; // o23 in the config string.
		logic spare_lo;
		logic reset_cold;
	} status_t;

	// captured pixel, stage 1 to stage 2.
	typedef struct packed {
		logic [color_w-1:0] red;
		logic [color_w-1:0] green;
		logic [color_w-1:0] blue;
		logic odd_line;
		logic hs;
		logic vs;
	} pixel_t;

endpackage

`default_nettype wire

/* rtl/pixel_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_capture
	import oric_av_pkg::*;
(
	input logic clk_sys,
	input logic rst_n,
	input logic r,
	input logic g,
	input logic b,
	input logic hs,
	input logic vs,
	input logic ce_pix,
	output pixel_t pix
);

	logic [color_w-1:0] red_q;
	logic [color_w-1:0] green_q;
	logic [color_w-1:0] blue_q;
	logic odd_q;
	logic hs_q;
	logic vs_q;
	logic hs_rise;
	logic vs_rise;

	// one colour bit to a full channel.
	function automatic logic [color_w-1:0] widen(input logic bit_in);
		logic [color_w-1:0] level;
		level = bit_in ? level_full : '0;
		return level;
	endfunction

	// hs_q and vs_q hold last cycle's syncs.
	assign hs_rise = hs & ~hs_q;
	assign vs_rise = vs & ~vs_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_q <= 1'b0;
			vs_q <= 1'b0;
		end else begin
			hs_q <= hs;
			vs_q <= vs;
		end
	end

	// line parity, a new frame starts on an even line.
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			odd_q <= 1'b0;
		else if (vs_rise)
			odd_q <= 1'b0;
		else if (hs_rise)
			odd_q <= ~odd_q;
	end

	// colour only moves on the pixel enable.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			red_q <= '0;
			green_q <= '0;
			blue_q <= '0;
		end else if (ce_pix) begin
			red_q <= widen(r);
			green_q <= widen(g);
			blue_q <= widen(b);
		end
	end

	assign pix = '{
		red: red_q,
		green: green_q,
		blue: blue_q,
		odd_line: odd_q,
		hs: hs_q,
		vs: vs_q
	};

endmodule

`default_nettype wire

/* rtl/scanline_shader.sv */
`timescale 1ns/100ps
`default_nettype none

module scanline_shader
	import oric_av_pkg::*;
(
	input logic clk_sys,
	input logic rst_n,
	input pixel_t pix,
	input status_t status,
	input logic scandoubler_d,
	output logic [color_w-1:0] vga_r,
	output logic [color_w-1:0] vga_g,
	output logic [color_w-1:0] vga_b,
	output logic vga_hs,
	output logic vga_vs
);

	logic [1:0] eff_mode;
	logic [color_w-1:0] dim_level;
	logic [color_w-1:0] red_d;
	logic [color_w-1:0] green_d;
	logic [color_w-1:0] blue_d;

	// scanlines only make sense with the scandoubler running.
	assign eff_mode = scandoubler_d ? 2'd0 : status.scanlines;
	assign dim_level = level_dim[eff_mode];

	// lit channels on odd lines take the dimmed level.
	function automatic logic [color_w-1:0] shade(
		input logic [color_w-1:0] chan,
		input logic odd,
		input logic [color_w-1:0] dimmed
	);
		logic [color_w-1:0] level;
		if (odd && chan != '0)
			level = dimmed;
		else
			level = chan;
		return level;
	endfunction

	always_comb begin
		red_d = shade(pix.red, pix.odd_line, dim_level);
		green_d = shade(pix.green, pix.odd_line, dim_level);
		blue_d = shade(pix.blue, pix.odd_line, dim_level);
	end

	// colours and syncs leave on the same edge.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			vga_r <= red_d;
			vga_g <= green_d;
			vga_b <= blue_d;
			vga_hs <= pix.hs;
			vga_vs <= pix.vs;
		end
	end

endmodule

`default_nettype wire

/* rtl/sigma_delta_dac.sv */
`timescale 1ns/100ps
`default_nettype none

module sigma_delta_dac
	import oric_av_pkg::*;
(
	input logic clk_sys,
	input logic rst_n,
	input logic [sample_w-1:0] audio,
	output logic audio_out
);

	logic [sample_w:0] acc; // carry in the top bit.
	logic [sample_w:0] acc_next;

	// the low bits keep the error, the carry drops out as a pulse.
	assign acc_next = {1'b0, acc[sample_w-1:0]} + {1'b0, audio};

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= acc_next;
	end

	// mean density is audio / 2**sample_w.
	assign audio_out = acc[sample_w];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module oric_av_out_tb -f vlog.f -o oric_av_out_sim &&
./obj_dir/oric_av_out_sim +verilator+error+limit+100 > sim.log 2>&1 ||
echo "build or simulation stopped early"
grep -qx "All checks passed" sim.log 2>/dev/null && exit 0 || exit 1

/* tests/oric_av_out_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module oric_av_out_asserts
	import oric_av_pkg::*;
(
	input logic clk_sys,
	input logic rst_n,
	input logic hs,
	input logic vs,
	input logic pix_odd,
	input logic [color_w-1:0] vga_r,
	input logic [color_w-1:0] vga_g,
	input logic [color_w-1:0] vga_b,
	input logic vga_hs,
	input logic vga_vs,
	input logic audio_out
);

	int unsigned fail_count = 0;
	logic started = 1'b0; // $past has history from the second edge on.

	always @(posedge clk_sys)
		started <= 1'b1;

	sync_delay: assert property (@(posedge clk_sys)
		rst_n && $past(rst_n) && $past(rst_n, 2) |->
			vga_hs == $past(hs, 2) && vga_vs == $past(vs, 2))
		else begin
			fail_count = fail_count + 1;
			$error("vga syncs are not the inputs two cycles earlier");
		end

	reset_state: assert property (@(posedge clk_sys)
		started && !$past(rst_n) |->
			vga_r == '0 && vga_g == '0 && vga_b == '0 && !vga_hs && !vga_vs && !audio_out)
		else begin
			fail_count = fail_count + 1;
			$error("outputs not zero after a reset cycle");
		end

	frame_even: assert property (@(posedge clk_sys)
		rst_n && vs && !$past(vs) |=> !pix_odd)
		else begin
			fail_count = fail_count + 1;
			$error("odd_line still set after a vs rising edge");
		end

endmodule

bind oric_av_out oric_av_out_asserts asserts_i (
	.clk_sys (clk_sys),
	.rst_n (rst_n),
	.hs (hs),
	.vs (vs),
	.pix_odd (pix.odd_line),
	.vga_r (vga_r),
	.vga_g (vga_g),
	.vga_b (vga_b),
	.vga_hs (vga_hs),
	.vga_vs (vga_vs),
	.audio_out (audio_out)
);

`default_nettype wire

/* tests/oric_av_out_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module oric_av_out_tb
	import oric_av_pkg::*;
();

	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic [1:0] mode;
		logic sd;
		logic odd;
		logic [color_w-1:0] exp_r;
		logic [color_w-1:0] exp_g;
		logic [color_w-1:0] exp_b;
	} row_t;

	localparam int n_rows = 13;
	localparam int reset_cycles = 5;
	localparam int audio_windows = 4;
	localparam int audio_len = 1024;
	localparam int row_cycles = 16; // vs and hs pulses, strobe wait, two stage delay.
	localparam int audio_cycles = reset_cycles + audio_len + 4;
	localparam int setup_cycles = 32;
	localparam int timeout_limit =
		2 * (setup_cycles + n_rows * row_cycles + audio_windows * audio_cycles);

	// r g b, mode, scandoubler_d, odd line, expected r g b.
	localparam row_t rows [0:n_rows-1] = '{
		'{1'b1, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0, 6'd63, 6'd0, 6'd0},
		'{1'b0, 1'b1, 1'b0, 2'd1, 1'b0, 1'b0, 6'd0, 6'd63, 6'd0},
		'{1'b0, 1'b0, 1'b1, 2'd2, 1'b0, 1'b0, 6'd0, 6'd0, 6'd63},
		'{1'b1, 1'b1, 1'b1, 2'd3, 1'b0, 1'b0, 6'd63, 6'd63, 6'd63},
		'{1'b0, 1'b0, 1'b0, 2'd3, 1'b0, 1'b1, 6'd0, 6'd0, 6'd0},
		'{1'b1, 1'b1, 1'b1, 2'd0, 1'b0, 1'b1, 6'd63, 6'd63, 6'd63},
		'{1'b1, 1'b1, 1'b1, 2'd1, 1'b0, 1'b1, 6'd47, 6'd47, 6'd47},
		'{1'b1, 1'b0, 1'b1, 2'd2, 1'b0, 1'b1, 6'd31, 6'd0, 6'd31},
		'{1'b1, 1'b1, 1'b1, 2'd3, 1'b0, 1'b1, 6'd15, 6'd15, 6'd15},
		'{1'b1, 1'b1, 1'b1, 2'd3, 1'b1, 1'b1, 6'd63, 6'd63, 6'd63},
		'{1'b0, 1'b1, 1'b1, 2'd2, 1'b1, 1'b1, 6'd0, 6'd63, 6'd63},
		'{1'b1, 1'b1, 1'b1, 2'd3, 1'b0, 1'b0, 6'd63, 6'd63, 6'd63},
		'{1'b1, 1'b1, 1'b1, 2'd1, 1'b1, 1'b0, 6'd63, 6'd63, 6'd63}
	};

	logic clk_sys = 1'b0;
	logic rst_n;
	logic r;
	logic g;
	logic b;
	logic hs;
	logic vs;
	logic ce_pix = 1'b0;
	status_t status;
	logic scandoubler_d;
	logic [sample_w-1:0] audio;
	logic [color_w-1:0] vga_r;
	logic [color_w-1:0] vga_g;
	logic [color_w-1:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic audio_out;

	logic [1:0] phase = 2'd0;
	logic [31:0] lfsr = 32'h48dd;
	int cycle_count = 0;
	int errors = 0;
	int errors_before = 0;
	int tests_run = 0;
	int tests_failed = 0;

	oric_av_out oric_av_out_i (
		.clk_sys (clk_sys),
		.rst_n (rst_n),
		.r (r),
		.g (g),
		.b (b),
		.hs (hs),
		.vs (vs),
		.ce_pix (ce_pix),
		.status (status),
		.scandoubler_d (scandoubler_d),
		.audio (audio),
		.vga_r (vga_r),
		.vga_g (vga_g),
		.vga_b (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs),
		.audio_out (audio_out)
	);

	always #20 clk_sys = ~clk_sys;

	// pixel enable, one cycle in four.
	always @(posedge clk_sys) begin
		phase <= phase + 2'd1;
		ce_pix <= (phase == 2'd3);
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_limit) begin
			$display("timeout: the run went past its limit of %0d cycles", timeout_limit);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'h80200003;
		return next;
	endfunction

	// one lfsr step per sample bit.
	task automatic draw_sample(output logic [sample_w-1:0] sample);
		sample = '0;
		for (int k = 0; k < sample_w; k++) begin
			sample = {sample[sample_w-2:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic status_t make_status(input logic [1:0] mode);
		status_t s;
		s = '0;
		s.scanlines = mode;
		return s;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_rgb(
		input logic [color_w-1:0] exp_r,
		input logic [color_w-1:0] exp_g,
		input logic [color_w-1:0] exp_b
	);
		check("vga_r", 32'(vga_r), 32'(exp_r));
		check("vga_g", 32'(vga_g), 32'(exp_g));
		check("vga_b", 32'(vga_b), 32'(exp_b));
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d mismatches", name, errors - errors_before);
		end
		errors_before = errors;
	endtask

	// returns on the negedge just before the DUT samples a pixel.
	task automatic wait_ce();
		do @(negedge clk_sys); while (!ce_pix);
	endtask

	initial begin
		row_t row;
		logic [sample_w-1:0] sample;
		logic [31:0] ones;
		logic [31:0] expected;
		rst_n = 1'b0;
		r = 1'b1; // everything active while in reset.
		g = 1'b1;
		b = 1'b1;
		hs = 1'b1;
		vs = 1'b1;
		status = make_status(2'd3);
		scandoubler_d = 1'b0;
		audio = '1;
		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		check_rgb(6'd0, 6'd0, 6'd0);
		check("vga_hs", 32'(vga_hs), 32'd0);
		check("vga_vs", 32'(vga_vs), 32'd0);
		check("audio_out", 32'(audio_out), 32'd0);
		end_test("reset");

		@(posedge clk_sys);
		rst_n <= 1'b1;
		r <= 1'b0;
		g <= 1'b0;
		b <= 1'b0;
		hs <= 1'b0;
		vs <= 1'b0;
		status <= make_status(2'd0);
		audio <= '0;

		// one cycle sync pulse, seen two cycles later.
		@(posedge clk_sys);
		hs <= 1'b1;
		vs <= 1'b1;
		@(posedge clk_sys);
		hs <= 1'b0;
		vs <= 1'b0;
		@(negedge clk_sys);
		check("vga_hs", 32'(vga_hs), 32'd0);
		check("vga_vs", 32'(vga_vs), 32'd0);
		@(negedge clk_sys);
		check("vga_hs", 32'(vga_hs), 32'd1);
		check("vga_vs", 32'(vga_vs), 32'd1);
		@(negedge clk_sys);
		check("vga_hs", 32'(vga_hs), 32'd0);
		check("vga_vs", 32'(vga_vs), 32'd0);
		end_test("sync delay");

		@(posedge clk_sys);
		r <= 1'b1;
		b <= 1'b1;
		wait_ce();
		@(posedge clk_sys);
		r <= 1'b0; // changes between strobes must not show.
		b <= 1'b0;
		@(negedge clk_sys);
		check_rgb(6'd0, 6'd0, 6'd0);
		repeat (4) begin
			@(negedge clk_sys);
			check_rgb(6'd63, 6'd0, 6'd63);
		end
		@(negedge clk_sys);
		check_rgb(6'd0, 6'd0, 6'd0);
		end_test("colour capture and hold");

		for (int i = 0; i < n_rows; i++) begin
			row = rows[i];
			@(posedge clk_sys);
			vs <= 1'b1; // frame start, even line.
			@(posedge clk_sys);
			vs <= 1'b0;
			if (row.odd) begin
				@(posedge clk_sys);
				hs <= 1'b1;
				@(posedge clk_sys);
				hs <= 1'b0;
			end
			@(posedge clk_sys);
			r <= row.r;
			g <= row.g;
			b <= row.b;
			status <= make_status(row.mode);
			scandoubler_d <= row.sd;
			wait_ce();
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_rgb(row.exp_r, row.exp_g, row.exp_b);
			end_test($sformatf("row %0d", i));
		end

		for (int i = 0; i < audio_windows; i++) begin
			draw_sample(sample);
			@(posedge clk_sys);
			audio <= sample;
			rst_n <= 1'b0;
			repeat (reset_cycles) @(posedge clk_sys);
			rst_n <= 1'b1;
			@(posedge clk_sys);
			ones = 0;
			repeat (audio_len) begin
				@(negedge clk_sys);
				if (audio_out)
					ones = ones + 1;
			end
			expected = (32'(audio_len) * 32'(sample)) >> 16;
			check("audio_out ones", ones,
				(ones + 1 >= expected && ones <= expected + 1) ? ones : expected);
			end_test($sformatf("audio sample %04h", sample));
		end

		$display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
			tests_run, tests_failed, errors, oric_av_out_i.asserts_i.fail_count);
		if (errors == 0 && oric_av_out_i.asserts_i.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/oric_av_pkg.sv
rtl/pixel_capture.sv
rtl/scanline_shader.sv
rtl/sigma_delta_dac.sv
rtl/oric_av_out.sv
tests/oric_av_out_asserts.sv
tests/oric_av_out_tb.sv
